/* hdl/segre_macros.svh */
`ifndef SEGRE_MACROS_SVH
`define SEGRE_MACROS_SVH

// Data path width
`define SEGRE_WORD_SIZE 32

// Register file geometry
`define SEGRE_REG_SIZE 5
`define SEGRE_NUM_REGS 32

// Result pipeline depth, fixed latency of the execute path
`define SEGRE_RVM_STAGES 5

`endif

/* hdl/segre_pkg.sv */
`include "segre_macros.svh"

package segre_pkg;

    // M-extension operations, codes shared with the golden vectors
    typedef enum logic [2:0] {
        ALU_MUL    = 3'd0,
        ALU_MULH   = 3'd1,
        ALU_MULHSU = 3'd2,
        ALU_MULHU  = 3'd3,
        ALU_DIV    = 3'd4,
        ALU_DIVU   = 3'd5,
        ALU_REM    = 3'd6,
        ALU_REMU   = 3'd7
    } alu_opcode_e;

    // Incoming request
    typedef struct packed {
        alu_opcode_e                 opcode;
        logic [`SEGRE_WORD_SIZE-1:0] src_a;
        logic [`SEGRE_WORD_SIZE-1:0] src_b;
        logic                        rf_we;
        logic [`SEGRE_REG_SIZE-1:0]  rf_waddr;
    } rvm_req_t;

    // Payload of one pipeline stage
    typedef struct packed {
        logic                        valid;
        logic [`SEGRE_WORD_SIZE-1:0] alu_res;
        logic                        rf_we;
        logic [`SEGRE_REG_SIZE-1:0]  rf_waddr;
    } rvm_data_t;

endpackage : segre_pkg

/* hdl/segre_register_file.sv */
`include "segre_macros.svh"

module segre_register_file (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Write port
    input  logic                         we_i,
    input  logic [`SEGRE_REG_SIZE-1:0]   waddr_i,
    input  logic [`SEGRE_WORD_SIZE-1:0]  wdata_i,

    // Asynchronous read port
    input  logic [`SEGRE_REG_SIZE-1:0]   raddr_i,
    output logic [`SEGRE_WORD_SIZE-1:0]  rdata_o
);

    logic [`SEGRE_WORD_SIZE-1:0] regs_q [`SEGRE_NUM_REGS];

    logic write_en;

    // x0 is hardwired, drop writes to it
    assign write_en = we_i && (waddr_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `SEGRE_NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end
        else if (write_en) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Same cycle read of a written register sees the old value
    assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

    a_x0_stays_zero: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        we_i |=> (regs_q[0] == '0)
    );

endmodule : segre_register_file

/* hdl/segre_rmv_stages.sv */
`include "segre_macros.svh"

module segre_rmv_stages (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Request
    input  logic                         req_valid_i,
    input  segre_pkg::rvm_req_t          req_i,

    // Completion
    output segre_pkg::rvm_data_t         wb_o,

    // Register file write port
    output logic                         rf_we_o,
    output logic [`SEGRE_REG_SIZE-1:0]   rf_waddr_o,
    output logic [`SEGRE_WORD_SIZE-1:0]  rf_wdata_o
);

    localparam int LAST = `SEGRE_RVM_STAGES - 1;

    logic [`SEGRE_WORD_SIZE-1:0] alu_res;

    segre_pkg::rvm_data_t stage_q [`SEGRE_RVM_STAGES];

    segre_rvm_alu u_alu (
        .alu_opcode_i (req_i.opcode),
        .alu_src_a_i  (req_i.src_a),
        .alu_src_b_i  (req_i.src_b),
        .alu_res_o    (alu_res)
    );

    // Stage one captures the request, the rest shift
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `SEGRE_RVM_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end
        else begin
            stage_q[0].valid    <= req_valid_i;
            stage_q[0].alu_res  <= alu_res;
            stage_q[0].rf_we    <= req_i.rf_we;
            stage_q[0].rf_waddr <= req_i.rf_waddr;
            for (int i = 1; i < `SEGRE_RVM_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign wb_o = stage_q[LAST];

    // Write only for a completing result that asked for it
    assign rf_we_o    = stage_q[LAST].valid & stage_q[LAST].rf_we;
    assign rf_waddr_o = stage_q[LAST].rf_waddr;
    assign rf_wdata_o = stage_q[LAST].alu_res;

    // ALU must never see an unknown operation on a live request
    a_opcode_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> !$isunknown(req_i.opcode)
    );

    a_result_known: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        stage_q[LAST].valid |-> !$isunknown(stage_q[LAST].alu_res)
    );

endmodule : segre_rmv_stages

/* hdl/segre_rvm_alu.sv */
`include "segre_macros.svh"

module segre_rvm_alu (
    input  segre_pkg::alu_opcode_e       alu_opcode_i,
    input  logic [`SEGRE_WORD_SIZE-1:0]  alu_src_a_i,
    input  logic [`SEGRE_WORD_SIZE-1:0]  alu_src_b_i,
    output logic [`SEGRE_WORD_SIZE-1:0]  alu_res_o
);

    localparam int W = `SEGRE_WORD_SIZE;

    localparam logic [W-1:0] ALL_ONES = {W{1'b1}};
    localparam logic [W-1:0] INT_MIN  = {1'b1, {(W-1){1'b0}}};

    // Full width products
    logic signed [2*W-1:0] mul_ss;
    logic        [2*W-1:0] mul_uu;
    logic signed [2*W-1:0] mul_su;

    logic [W-1:0] div_res;
    logic [W-1:0] divu_res;
    logic [W-1:0] rem_res;
    logic [W-1:0] remu_res;

    logic div_by_zero;
    logic div_overflow;

    // Products
    always_comb begin
        mul_ss = $signed(alu_src_a_i) * $signed(alu_src_b_i);
        mul_uu = alu_src_a_i * alu_src_b_i;
        // Operand a sign extended, operand b zero extended
        mul_su = $signed({alu_src_a_i[W-1], alu_src_a_i}) * $signed({1'b0, alu_src_b_i});
    end

    assign div_by_zero  = (alu_src_b_i == '0);
    assign div_overflow = (alu_src_a_i == INT_MIN) && (alu_src_b_i == ALL_ONES);

    // Signed quotient and remainder
    always_comb begin
        if (div_by_zero) begin
            div_res = ALL_ONES;
            rem_res = alu_src_a_i;
        end
        else if (div_overflow) begin
            div_res = alu_src_a_i;
            rem_res = '0;
        end
        else begin
            div_res = $signed(alu_src_a_i) / $signed(alu_src_b_i);
            rem_res = $signed(alu_src_a_i) % $signed(alu_src_b_i);
        end
    end

    // Unsigned quotient and remainder, no overflow case
    always_comb begin
        if (div_by_zero) begin
            divu_res = ALL_ONES;
            remu_res = alu_src_a_i;
        end
        else begin
            divu_res = alu_src_a_i / alu_src_b_i;
            remu_res = alu_src_a_i % alu_src_b_i;
        end
    end

    // Result select
    always_comb begin
        case (alu_opcode_i)
            segre_pkg::ALU_MUL: begin
                alu_res_o = mul_ss[W-1:0];
            end
            segre_pkg::ALU_MULH: begin
                alu_res_o = mul_ss[2*W-1:W];
            end
            segre_pkg::ALU_MULHSU: begin
                alu_res_o = mul_su[2*W-1:W];
            end
            segre_pkg::ALU_MULHU: begin
                alu_res_o = mul_uu[2*W-1:W];
            end
            segre_pkg::ALU_DIV: begin
                alu_res_o = div_res;
            end
            segre_pkg::ALU_DIVU: begin
                alu_res_o = divu_res;
            end
            segre_pkg::ALU_REM: begin
                alu_res_o = rem_res;
            end
            segre_pkg::ALU_REMU: begin
                alu_res_o = remu_res;
            end
            default: begin
                alu_res_o = '0;
            end
        endcase
    end

endmodule : segre_rvm_alu

/* hdl/segre_rvm_top.sv */
`include "segre_macros.svh"

module segre_rvm_top (
    input  logic                         clk_i,
    input  logic                         rst_n_i,

    // Request strobe and payload
    input  logic                         req_valid_i,
    input  segre_pkg::rvm_req_t          req_i,

    // Completing result
    output segre_pkg::rvm_data_t         wb_o,

    // Register file read port
    input  logic [`SEGRE_REG_SIZE-1:0]   rf_raddr_i,
    output logic [`SEGRE_WORD_SIZE-1:0]  rf_rdata_o
);

    logic                        rf_we;
    logic [`SEGRE_REG_SIZE-1:0]  rf_waddr;
    logic [`SEGRE_WORD_SIZE-1:0] rf_wdata;

    segre_rmv_stages u_stages (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .wb_o        (wb_o),
        .rf_we_o     (rf_we),
        .rf_waddr_o  (rf_waddr),
        .rf_wdata_o  (rf_wdata)
    );

    segre_register_file u_register_file (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule : segre_rvm_top

/* project.f */
+incdir+hdl
hdl/segre_pkg.sv
hdl/segre_rvm_alu.sv
hdl/segre_rmv_stages.sv
hdl/segre_register_file.sv
hdl/segre_rvm_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the M-extension testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    -f project.f --top-module tb_top -Mdir "$BUILD_DIR" -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/tb_top_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
else
    exit 1
fi

/* testbench/segre_rvm_golden.txt */
# opcode (0 MUL 1 MULH 2 MULHSU 3 MULHU 4 DIV 5 DIVU 6 REM 7 REMU) src_a src_b rd expected
# All columns hex, one vector per line
0 00000007 00000006 01 0000002A
0 FFFFFFFD 00000005 02 FFFFFFF1
0 12345678 00000010 03 23456780
1 FFFFFFFF 00000002 04 FFFFFFFF
1 80000000 00000004 05 FFFFFFFE
1 7FFFFFFF 7FFFFFFF 06 3FFFFFFF
2 FFFFFFFF FFFFFFFF 07 FFFFFFFF
2 80000000 00000004 08 FFFFFFFE
2 00000002 80000000 09 00000001
3 FFFFFFFF FFFFFFFF 0A FFFFFFFE
3 80000000 00000004 0B 00000002
4 00000014 00000003 0C 00000006
4 FFFFFFEC 00000003 0D FFFFFFFA
4 00000055 00000000 0E FFFFFFFF
4 80000000 FFFFFFFF 0F 80000000
5 FFFFFFFF 00000010 10 0FFFFFFF
5 12345678 00000000 11 FFFFFFFF
6 FFFFFFEC 00000003 12 FFFFFFFE
6 FFFFFFF9 00000000 13 FFFFFFF9
6 80000000 FFFFFFFF 14 00000000
7 FFFFFFFF 00000010 15 0000000F
7 0000ABCD 00000000 16 0000ABCD
0 00000009 00000009 00 00000051
0 00010000 00010000 17 00000000
6 00000014 FFFFFFFA 18 00000002

/* testbench/tb_checker.sv */
`include "segre_macros.svh"

module tb_checker (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  logic                         req_valid_i,
    input  segre_pkg::rvm_data_t         wb_i,
    input  logic [`SEGRE_REG_SIZE-1:0]   rf_raddr_i,
    input  logic [`SEGRE_WORD_SIZE-1:0]  rf_rdata_i,
    input  logic                         end_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Valid shows after the fourth edge past sampling, written at the fifth
    localparam int WB_EDGE = `SEGRE_RVM_STAGES - 1;

    int   pass_cnt = 0;
    int   fail_cnt = 0;
    int   pending [$];
    logic reported = 1'b0;

    function automatic string op_name(input logic [2:0] code);
        case (code)
            3'd0:    return "MUL";
            3'd1:    return "MULH";
            3'd2:    return "MULHSU";
            3'd3:    return "MULHU";
            3'd4:    return "DIV";
            3'd5:    return "DIVU";
            3'd6:    return "REM";
            default: return "REMU";
        endcase
    endfunction

    function automatic string test_name(input int idx);
        return $sformatf("vec%0d_%s_x%0d", idx, op_name(tb_top.vec_op[idx]),
                         tb_top.vec_rd[idx]);
    endfunction

    task automatic check_equal(input string name, input string field,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        if (exp_val === act_val) begin
            pass_cnt++;
            $display("PASS %s %s %08h", name, field, act_val);
        end
        else begin
            fail_cnt++;
            $display("CHECK FAILED %s %s expected %08h actual %08h",
                     name, field, exp_val, act_val);
        end
    endtask

    task automatic report_error(input string msg);
        fail_cnt++;
        $display("ERROR %s", msg);
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk_i) begin
        int    idx;
        int    delay;
        string name;
        logic [31:0] exp_val;

        if (wb_i.valid) begin
            if (!rst_n_i) begin
                report_error("writeback valid while reset is asserted");
            end
            else if (pending.size() == 0) begin
                report_error($sformatf("unexpected writeback at cycle %0d, none outstanding",
                                       tb_top.cycle_cnt));
            end
            else begin
                idx   = pending.pop_front();
                name  = test_name(idx);
                delay = tb_top.cycle_cnt - tb_top.issue_cycle[idx];
                if (delay != WB_EDGE) begin
                    report_error($sformatf("%s writeback came %0d edges after issue, not %0d",
                                           name, delay, WB_EDGE));
                end
                else if (!wb_i.rf_we) begin
                    report_error($sformatf("%s writeback has its write enable low", name));
                end
                else if (wb_i.rf_waddr != tb_top.vec_rd[idx]) begin
                    check_equal(name, "destination", 32'(tb_top.vec_rd[idx]),
                                32'(wb_i.rf_waddr));
                end
                else begin
                    check_equal(name, "result", tb_top.vec_exp[idx], wb_i.alu_res);
                end
            end
        end

        if (req_valid_i) begin
            pending.push_back(tb_top.cur_idx);
        end

        // x0 must ignore the write aimed at it
        if (tb_top.rd_active) begin
            idx     = tb_top.rd_idx;
            exp_val = (tb_top.vec_rd[idx] == '0) ? '0 : tb_top.vec_exp[idx];
            check_equal($sformatf("readback_x%0d", rf_raddr_i), "register", exp_val,
                        rf_rdata_i);
        end

        if (end_i && !reported) begin
            if (pending.size() != 0) begin
                report_error($sformatf("%0d requests never produced a writeback",
                                       pending.size()));
            end
            $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
            reported = 1'b1;
        end
    end

endmodule : tb_checker

/* testbench/tb_top.sv */
`include "segre_macros.svh"

module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_VEC    = 64;
    localparam int BURST_LEN  = `SEGRE_RVM_STAGES;

    logic                        clk;
    logic                        rst_n;
    logic                        req_valid;
    segre_pkg::rvm_req_t         req;
    segre_pkg::rvm_data_t        wb;
    logic [`SEGRE_REG_SIZE-1:0]  rf_raddr;
    logic [`SEGRE_WORD_SIZE-1:0] rf_rdata;

    // Golden vectors, the checker reads them too
    logic [2:0]                  vec_op      [MAX_VEC];
    logic [`SEGRE_WORD_SIZE-1:0] vec_a       [MAX_VEC];
    logic [`SEGRE_WORD_SIZE-1:0] vec_b       [MAX_VEC];
    logic [`SEGRE_REG_SIZE-1:0]  vec_rd      [MAX_VEC];
    logic [`SEGRE_WORD_SIZE-1:0] vec_exp     [MAX_VEC];
    int                          issue_cycle [MAX_VEC];
    int                          n_vec = 0;
    logic                        loaded = 1'b0;

    int          cycle_cnt = 0;
    int          cur_idx;
    int          rd_idx;
    logic        rd_active;
    logic        end_run;
    logic [15:0] lfsr;

    segre_rvm_top dut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .wb_o        (wb),
        .rf_raddr_i  (rf_raddr),
        .rf_rdata_o  (rf_rdata)
    );

    tb_checker u_checker (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .wb_i        (wb),
        .rf_raddr_i  (rf_raddr),
        .rf_rdata_i  (rf_rdata),
        .end_i       (end_run)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic random_gap(output int gap);
        logic b0;
        logic b1;
        lfsr = lfsr_next(lfsr);
        b0   = lfsr[0];
        lfsr = lfsr_next(lfsr);
        b1   = lfsr[0];
        gap  = 2 * int'(b1) + int'(b0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the sampling edge
    task automatic issue_vector(input int idx);
        segre_pkg::rvm_req_t r;
        r.opcode   = segre_pkg::alu_opcode_e'(vec_op[idx]);
        r.src_a    = vec_a[idx];
        r.src_b    = vec_b[idx];
        r.rf_we    = 1'b1;
        r.rf_waddr = vec_rd[idx];
        cur_idx          = idx;
        issue_cycle[idx] = cycle_cnt + 1;
        req              = r;
        req_valid        = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    initial begin
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_rd;
        logic [31:0] f_exp;
        fd = $fopen("testbench/segre_rvm_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden vector file");
            $display("Simulation failed");
            $finish;
        end
        else begin
            while (!$feof(fd) && n_vec < MAX_VEC) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_rd, f_exp);
                    if (cnt == 5) begin
                        vec_op[n_vec]  = f_op[2:0];
                        vec_a[n_vec]   = f_a;
                        vec_b[n_vec]   = f_b;
                        vec_rd[n_vec]  = f_rd[`SEGRE_REG_SIZE-1:0];
                        vec_exp[n_vec] = f_exp;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end
    end

    initial begin
        int gap;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rf_raddr  = '0;
        rd_active = 1'b0;
        rd_idx    = 0;
        cur_idx   = 0;
        end_run   = 1'b0;
        lfsr      = 16'd59889;
        wait (loaded);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Opening burst fills the whole pipeline
        for (int i = 0; i < n_vec; i++) begin
            issue_vector(i);
            if (i >= BURST_LEN - 1) begin
                random_gap(gap);
                idle_cycles(gap);
            end
        end
        idle_cycles(`SEGRE_RVM_STAGES + 1);

        rd_active = 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            rd_idx   = i;
            rf_raddr = vec_rd[i];
            idle_cycles(1);
        end
        rd_active = 1'b0;
        end_run   = 1'b1;
        @(negedge clk);
        #1;
        if (u_checker.fail_cnt == 0 && u_checker.pass_cnt > 0) begin
            $display("Simulation passed");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        int limit_cycles;
        wait (loaded);
        limit_cycles = n_vec * 4 + 5 + n_vec + 20;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule : tb_top
